/* design/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// baud divisor is scaled by 2**UART_PRESCALE before compare
`define UART_PRESCALE 0
`define UART_RESET_DLL 8'd1
// start + 8 data + parity + 2 stop
`define UART_FRAME_BITS 12

// register map, 3-bit address
`define UART_ADDR_RBR_DLL 3'd0
`define UART_ADDR_IER_DLM 3'd1
`define UART_ADDR_IIR 3'd2
`define UART_ADDR_LCR 3'd3
`define UART_ADDR_MCR 3'd4
`define UART_ADDR_LSR 3'd5
`define UART_ADDR_MSR 3'd6
`define UART_ADDR_SCR 3'd7

`endif

/* design/uartPkg.sv */
`default_nettype none

package uartPkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [2:0]  regAddrT;   // one of eight byte registers
  typedef logic [7:0]  byteT;      // bus data
  typedef logic [15:0] divisorT;   // {DLM, DLL}
  typedef logic [1:0]  wordLenT;   // 00 = 5 bits up to 11 = 8 bits
  typedef logic [4:0]  mcrT;       // bit 4 = loopback
  typedef logic [3:0]  modemVecT;  // 0 cts, 1 dsr, 2 ri, 3 dcd
  typedef logic [1:0]  lineHistT;  // {current, previous} sample of one line

  // transmitter states
  typedef enum logic [1:0] {
    txIdle,
    txActive,
    txDone
  } txStateT;

endpackage

`default_nettype wire

/* design/uartIf.sv */
`default_nettype none

// link between register file and transmitter
interface txLineIf import uartPkg::*; ();

  // line control fields, straight out of LCR
  wordLenT wordLen;     // LCR[1:0]
  logic    parityEn;    // LCR[3]
  logic    evenParity;  // LCR[4]
  logic    stopTwo;     // LCR[2]

  // holding register write
  byteT    thrData;
  logic    thrLoad;     // one cycle, THR write with DLAB clear

  // status back to LSR and IIR
  logic    thrEmpty;    // THRE
  logic    shiftEmpty;  // no frame in the shifter

  modport regs (
    output wordLen,
    output parityEn,
    output evenParity,
    output stopTwo,
    output thrData,
    output thrLoad,
    input  thrEmpty,
    input  shiftEmpty
  );

  modport tx (
    input  wordLen,
    input  parityEn,
    input  evenParity,
    input  stopTwo,
    input  thrData,
    input  thrLoad,
    output thrEmpty,
    output shiftEmpty
  );

endinterface

`default_nettype wire

/* design/baudGen.sv */
`include "uart_settings.svh"

`default_nettype none

module baudGen import uartPkg::*; (
  input  logic    PCLK,
  input  logic    PRESETn,
  input  divisorT divisor,
  input  logic    divisorWrite,
  output logic    baudTick      // one cycle, 16 per serial bit
);

  localparam int CntW = $bits(divisorT) + `UART_PRESCALE;

  logic [CntW-1:0] count;
  logic [CntW-1:0] limit;
  logic            hit;

  // period = divisor * 2**prescale cycles
  assign limit = CntW'(divisor) << `UART_PRESCALE;
  assign hit   = (count == limit);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      count    <= CntW'(1);
      baudTick <= 1'b0;
    end else if (divisorWrite) begin
      count    <= CntW'(1);  // new divisor, start over
      baudTick <= 1'b0;
    end else begin
      baudTick <= hit;
      count    <= hit ? CntW'(1) : count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/uartTx.sv */
`include "uart_settings.svh"

`default_nettype none

module uartTx import uartPkg::*; (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic baudTick,
  txLineIf.tx  line,
  output logic SOUT
);

  localparam int FrameW = `UART_FRAME_BITS;

  byteT              thr;        // holding register
  logic              thrFull;
  logic [FrameW-1:0] frame;      // MSB goes out first
  logic [FrameW-1:0] shiftReg;
  logic [3:0]        nData;      // 5 to 8
  logic [3:0]        frameLen;   // 7 to 12
  logic [3:0]        bitsLeft;
  logic [3:0]        tickCnt;    // 16 ticks per bit
  byteT              dataMask;
  logic              parity;
  logic              shiftEmpty;
  logic              startTx;
  logic              bitEdge;
  txStateT           state;

  //////////////////////////////////////////////////
  // frame builder
  //////////////////////////////////////////////////

  assign nData    = 4'd5 + {2'b00, line.wordLen};
  assign frameLen = nData + 4'd2 + {3'b000, line.parityEn} + {3'b000, line.stopTwo};
  assign dataMask = 8'hFF >> (2'd3 - line.wordLen);

  // odd parity unless even is selected
  assign parity = ^(thr & dataMask) ^ ~line.evenParity;

  always_comb begin
    frame = '1;              // stop bits and padding
    frame[FrameW-1] = 1'b0;  // start bit
    for (int i = 0; i < 8; i++) begin
      if (i < nData) frame[FrameW-2-i] = thr[i];  // LSB first
    end
    if (line.parityEn) frame[FrameW-2-nData] = parity;
  end

  //////////////////////////////////////////////////
  // holding and shift registers
  //////////////////////////////////////////////////

  assign startTx = (state == txIdle) & thrFull;
  assign bitEdge = (state == txActive) & baudTick & (tickCnt == 4'd0);

  always_ff @(posedge PCLK) begin
    if (line.thrLoad) thr <= line.thrData;
    if (startTx) shiftReg <= frame;
    else if (bitEdge) shiftReg <= {shiftReg[FrameW-2:0], 1'b1};
  end

  //////////////////////////////////////////////////
  // transmit FSM
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      thrFull    <= 1'b0;
      shiftEmpty <= 1'b1;
      state      <= txIdle;
      tickCnt    <= '0;
      bitsLeft   <= '0;
      SOUT       <= 1'b1;  // line idles high
    end else begin
      if (startTx) thrFull <= 1'b0;
      if (line.thrLoad) thrFull <= 1'b1;  // late write overrides the move
      case (state)
        txIdle: begin
          if (startTx) begin
            state      <= txActive;
            tickCnt    <= '0;        // first bit starts on the next tick
            bitsLeft   <= frameLen;  // latched, LCR may change mid frame
            shiftEmpty <= 1'b0;
          end
        end
        txActive: begin
          if (baudTick) begin
            tickCnt <= tickCnt + 4'd1;
            if (tickCnt == 4'd0) begin
              if (bitsLeft == 4'd0) begin
                state <= txDone;  // last stop bit just ended
              end else begin
                SOUT     <= shiftReg[FrameW-1];
                bitsLeft <= bitsLeft - 4'd1;
              end
            end
          end
        end
        txDone: begin
          state      <= txIdle;
          shiftEmpty <= 1'b1;  // TEMT one cycle after the stop bit
        end
        default: state <= txIdle;
      endcase
    end
  end

  assign line.thrEmpty   = ~thrFull;
  assign line.shiftEmpty = shiftEmpty;

endmodule

`default_nettype wire

/* design/modemLoopback.sv */
`default_nettype none

module modemLoopback import uartPkg::*; (
  input  logic     PCLK,
  input  logic     PRESETn,
  input  mcrT      mcr,
  input  logic     DSRb,
  input  logic     DCDb,
  input  logic     CTSb,
  input  logic     RIb,
  output modemVecT lineSync,  // first sync stage, active low
  output logic     DTRb,
  output logic     RTSb,
  output logic     OUT1b,
  output logic     OUT2b
);

  logic     loop;
  modemVecT pinVec;
  modemVecT loopVec;

  assign loop = mcr[4];

  // outputs parked high in loopback
  assign DTRb  = ~mcr[0] | loop;
  assign RTSb  = ~mcr[1] | loop;
  assign OUT1b = ~mcr[2] | loop;
  assign OUT2b = ~mcr[3] | loop;

  assign pinVec  = {DCDb, RIb, DSRb, CTSb};
  assign loopVec = {~mcr[3], ~mcr[2], ~mcr[0], ~mcr[1]};  // out2, out1, dtr, rts

  always_ff @(posedge PCLK) begin
    if (!PRESETn) lineSync <= '1;  // all lines inactive
    else lineSync <= loop ? loopVec : pinVec;
  end

endmodule

`default_nettype wire

/* design/modemLineMonitor.sv */
`default_nettype none

module modemLineMonitor import uartPkg::*; #(
  parameter bit trailingOnly = 1'b0  // RI style, flag the end of the pulse only
) (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic lineIn,      // from the first sync stage
  input  logic clearDelta,  // MSR read
  output logic level,
  output logic delta
);

  lineHistT hist;  // [1] second sync stage, [0] one cycle older
  logic     changed;
  logic     rose;
  logic     hit;

  assign level   = hist[1];
  assign changed = hist[1] ^ hist[0];
  assign rose    = hist[1] & ~hist[0];  // active-low line going inactive
  assign hit     = trailingOnly ? rose : changed;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      hist  <= '1;
      delta <= 1'b0;
    end else begin
      hist  <= {lineIn, hist[1]};
      delta <= hit | (delta & ~clearDelta);  // a fresh change beats the clear
    end
  end

endmodule

`default_nettype wire

/* design/uartRegs.sv */
`include "uart_settings.svh"

`default_nettype none

module uartRegs import uartPkg::*; (
  input  logic     PCLK,
  input  logic     PRESETn,
  input  regAddrT  A,
  input  byteT     Din,
  input  logic     MEMRb,
  input  logic     MEMWb,
  input  modemVecT lineLevel,     // synced pin levels, active low
  input  modemVecT lineDelta,     // sticky change flags
  output byteT     Dout,
  output logic     INTR,
  output divisorT  divisor,
  output logic     divisorWrite,  // restarts the baud counter
  output mcrT      mcr,
  output logic     clearDeltas,   // MSR read side effect
  txLineIf.regs    tx
);

  logic [3:0] ier;  // only the low nibble exists
  byteT       lcr;
  byteT       scr;
  byteT       dll;
  byteT       dlm;
  logic       rd;
  logic       wr;
  logic       dlab;
  logic       thre;
  logic       temt;
  logic       threPending;
  logic       squash;  // THRE interrupt acknowledged by an IIR read
  byteT       lsr;
  byteT       msr;
  byteT       iir;

  assign rd   = ~MEMRb;
  assign wr   = ~MEMWb;
  assign dlab = lcr[7];

  //////////////////////////////////////////////////
  // writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      ier <= '0;
      lcr <= 8'h03;  // 8N1
      mcr <= '0;
      scr <= '0;
      dll <= `UART_RESET_DLL;
      dlm <= '0;
    end else if (wr) begin
      case (A)
        `UART_ADDR_RBR_DLL: begin
          if (dlab) dll <= Din;  // THR side handled by the transmitter
        end
        `UART_ADDR_IER_DLM: begin
          if (dlab) dlm <= Din;
          else ier <= Din[3:0];
        end
        `UART_ADDR_LCR: lcr <= Din;
        `UART_ADDR_MCR: mcr <= Din[4:0];
        `UART_ADDR_SCR: scr <= Din;
        default: ;  // FCR, LSR and MSR writes have no effect
      endcase
    end
  end

  // strobes, each one cycle wide because the bus strobe is
  assign tx.thrLoad   = wr & (A == `UART_ADDR_RBR_DLL) & ~dlab;
  assign divisorWrite = wr & dlab & ((A == `UART_ADDR_RBR_DLL) | (A == `UART_ADDR_IER_DLM));
  assign clearDeltas  = rd & (A == `UART_ADDR_MSR);

  // LCR fields and data toward the transmitter
  assign tx.wordLen    = lcr[1:0];
  assign tx.stopTwo    = lcr[2];
  assign tx.parityEn   = lcr[3];
  assign tx.evenParity = lcr[4];
  assign tx.thrData    = Din;

  assign divisor = {dlm, dll};

  //////////////////////////////////////////////////
  // status and interrupt
  //////////////////////////////////////////////////

  assign thre = tx.thrEmpty;
  assign temt = thre & tx.shiftEmpty;  // holding and shift register both drained

  assign threPending = thre & ier[1] & ~squash;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      squash <= 1'b0;
      INTR   <= 1'b0;
    end else begin
      INTR <= threPending;  // registered pin, one cycle behind
      if (!thre) begin
        squash <= 1'b0;  // new byte re-arms the interrupt
      end else if (rd && (A == `UART_ADDR_IIR) && threPending) begin
        squash <= 1'b1;
      end
    end
  end

  assign lsr = {1'b0, temt, thre, 5'b0_0000};
  assign msr = {~lineLevel, lineDelta};       // levels up, deltas down
  assign iir = threPending ? 8'h02 : 8'h01;  // bit 0 low = pending

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  always_comb begin
    Dout = '0;
    if (rd) begin
      case (A)
        `UART_ADDR_RBR_DLL: Dout = dlab ? dll : 8'h00;  // no receiver behind RBR
        `UART_ADDR_IER_DLM: Dout = dlab ? dlm : {4'h0, ier};
        `UART_ADDR_IIR:     Dout = iir;
        `UART_ADDR_LCR:     Dout = lcr;
        `UART_ADDR_MCR:     Dout = {3'b000, mcr};
        `UART_ADDR_LSR:     Dout = lsr;
        `UART_ADDR_MSR:     Dout = msr;
        `UART_ADDR_SCR:     Dout = scr;
        default:            Dout = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uartTop.sv */
`default_nettype none

module uartTop import uartPkg::*; (
  input  logic    PCLK,
  input  logic    PRESETn,
  input  regAddrT A,
  input  byteT    Din,
  input  logic    MEMRb,
  input  logic    MEMWb,
  input  logic    DSRb,
  input  logic    DCDb,
  input  logic    CTSb,
  input  logic    RIb,
  output byteT    Dout,
  output logic    INTR,
  output logic    SOUT,
  output logic    RTSb,
  output logic    DTRb,
  output logic    OUT1b,
  output logic    OUT2b
);

  divisorT  divisor;
  logic     divisorWrite;
  logic     baudTick;
  mcrT      mcr;
  modemVecT lineSync;
  modemVecT lineLevel;
  modemVecT lineDelta;
  logic     clearDeltas;

  txLineIf txLine ();

  uartRegs regFile (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .A            (A),
    .Din          (Din),
    .MEMRb        (MEMRb),
    .MEMWb        (MEMWb),
    .lineLevel    (lineLevel),
    .lineDelta    (lineDelta),
    .Dout         (Dout),
    .INTR         (INTR),
    .divisor      (divisor),
    .divisorWrite (divisorWrite),
    .mcr          (mcr),
    .clearDeltas  (clearDeltas),
    .tx           (txLine.regs)
  );

  baudGen baud (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .divisor      (divisor),
    .divisorWrite (divisorWrite),
    .baudTick     (baudTick)
  );

  uartTx txPath (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .baudTick (baudTick),
    .line     (txLine.tx),
    .SOUT     (SOUT)
  );

  modemLoopback modem (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .mcr      (mcr),
    .DSRb     (DSRb),
    .DCDb     (DCDb),
    .CTSb     (CTSb),
    .RIb      (RIb),
    .lineSync (lineSync),
    .DTRb     (DTRb),
    .RTSb     (RTSb),
    .OUT1b    (OUT1b),
    .OUT2b    (OUT2b)
  );

  //////////////////////////////////////////////////
  // one monitor per modem line, RI at index 2
  //////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < 4; i++) begin : gLineMon
      modemLineMonitor #(
        .trailingOnly (i == 2)
      ) mon (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .lineIn     (lineSync[i]),
        .clearDelta (clearDeltas),
        .level      (lineLevel[i]),
        .delta      (lineDelta[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

/* tests/uartTb.sv */
`include "uart_settings.svh"

`default_nettype none

module uartTb import uartPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TxDivisor    = 2;
  localparam int BitCycles    = 16 * TxDivisor;  // prescale 0
  localparam int MaxFrameBits = 12;
  localparam int NumFrames    = 10;
  // every frame plus the one sent by the interrupt test, one bit of latency each
  localparam int CycleLimit   = (NumFrames + 1) * (MaxFrameBits + 2) * BitCycles + 2000;

  logic    PCLK = 1'b0;
  logic    PRESETn;
  regAddrT A;
  byteT    Din;
  logic    MEMRb;
  logic    MEMWb;
  logic    DSRb;
  logic    DCDb;
  logic    CTSb;
  logic    RIb;
  byteT    Dout;
  logic    INTR;
  logic    SOUT;
  logic    RTSb;
  logic    DTRb;
  logic    OUT1b;
  logic    OUT2b;

  int errCount    = 0;
  int errAtStart  = 0;  // error count when the current test began
  int failedTests = 0;
  int cycleCount  = 0;

  uartTop dut (.*);

  always #10 PCLK = ~PCLK;  // 20 ns period

  // line and interrupt pins sit at their idle levels through reset
  resetLevels: assert property (@(posedge PCLK) !PRESETn |=> (SOUT && !INTR))
    else begin
      errCount++;
      $display("ERROR %0t: reset levels expected SOUT 1 INTR 0, got SOUT %b INTR %b",
               $time, $sampled(SOUT), $sampled(INTR));
    end

  //////////////////////////////////////////////////
  // bus and check helpers
  //////////////////////////////////////////////////

  task automatic writeReg(input regAddrT addr, input byteT data);
    @(negedge PCLK);
    A     = addr;
    Din   = data;
    MEMWb = 1'b0;  // one cycle strobe
    @(negedge PCLK);
    MEMWb = 1'b1;
  endtask

  task automatic readReg(input regAddrT addr, output byteT data);
    @(negedge PCLK);
    A     = addr;
    MEMRb = 1'b0;
    #5;
    data = Dout;  // sampled before the edge that applies read side effects
    @(negedge PCLK);
    MEMRb = 1'b1;
  endtask

  task automatic compareByte(input string what, input byteT got, input byteT exp);
    assert (got === exp)
      else begin
        errCount++;
        $display("ERROR %0t: %s expected %02h, got %02h", $time, what, exp, got);
      end
  endtask

  task automatic reportTest(input int num, input string name);
    if (errCount == errAtStart) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      failedTests++;
      $display("test %0d %s: %0d errors", num, name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  // poll LSR until TEMT, bounded by a number of reads
  task automatic waitTxEmpty(input int maxReads);
    byteT rdata;
    int   n;
    rdata = '0;
    n     = 0;
    while (!rdata[6] && n < maxReads) begin
      readReg(`UART_ADDR_LSR, rdata);
      n++;
    end
    compareByte("LSR TEMT after frame", {7'b0, rdata[6]}, 8'h01);
  endtask

  //////////////////////////////////////////////////
  // serial frame decoder
  //////////////////////////////////////////////////

  task automatic decodeFrame(input byteT data, input byteT lcrVal);
    int   nData;
    int   nStop;
    logic par;
    byteT mask;
    byteT got;
    byteT rdata;
    nData = 5 + lcrVal[1:0];
    nStop = lcrVal[2] ? 2 : 1;
    mask  = 8'hFF >> (8 - nData);
    got   = '0;
    par   = 1'b0;
    for (int i = 0; i < nData; i++) par = par ^ data[i];
    if (!lcrVal[4]) par = ~par;  // odd parity makes the count of ones odd
    @(negedge SOUT);
    repeat (BitCycles / 2) @(negedge PCLK);  // middle of the start bit
    compareByte("start bit", {7'b0, SOUT}, 8'h00);
    for (int i = 0; i < nData; i++) begin
      repeat (BitCycles) @(negedge PCLK);
      got[i] = SOUT;  // LSB first
    end
    compareByte("data bits", got, data & mask);
    if (lcrVal[3]) begin
      repeat (BitCycles) @(negedge PCLK);
      compareByte("parity bit", {7'b0, SOUT}, {7'b0, par});
    end
    for (int i = 0; i < nStop; i++) begin
      repeat (BitCycles) @(negedge PCLK);
      compareByte("stop bit", {7'b0, SOUT}, 8'h01);
    end
    // still sending in the middle of the last stop bit, empty soon after it
    readReg(`UART_ADDR_LSR, rdata);
    compareByte("LSR TEMT during last stop bit", {7'b0, rdata[6]}, 8'h00);
    waitTxEmpty(BitCycles / 2);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic resetValues();
    byteT rdata;
    readReg(`UART_ADDR_LCR, rdata);
    compareByte("LCR reset", rdata, 8'h03);
    readReg(`UART_ADDR_LSR, rdata);
    compareByte("LSR reset", rdata, 8'h60);
    readReg(`UART_ADDR_IIR, rdata);
    compareByte("IIR reset", rdata, 8'h01);
    readReg(`UART_ADDR_IER_DLM, rdata);
    compareByte("IER reset", rdata, 8'h00);
    readReg(`UART_ADDR_MCR, rdata);
    compareByte("MCR reset", rdata, 8'h00);
    readReg(`UART_ADDR_SCR, rdata);
    compareByte("SCR reset", rdata, 8'h00);
    compareByte("idle pins", {3'b0, SOUT, DTRb, RTSb, OUT1b, OUT2b}, 8'h1F);
    compareByte("INTR reset", {7'b0, INTR}, 8'h00);
    writeReg(`UART_ADDR_LCR, 8'h83);  // DLAB on
    readReg(`UART_ADDR_RBR_DLL, rdata);
    compareByte("DLL reset", rdata, 8'h01);
    readReg(`UART_ADDR_IER_DLM, rdata);
    compareByte("DLM reset", rdata, 8'h00);
    writeReg(`UART_ADDR_LCR, 8'h03);
  endtask

  task automatic registerAccess();
    byteT v;
    byteT ierVal;
    byteT dllVal;
    byteT dlmVal;
    byteT rdata;
    v = byteT'($urandom);
    writeReg(`UART_ADDR_SCR, v);
    readReg(`UART_ADDR_SCR, rdata);
    compareByte("SCR readback", rdata, v);
    v = byteT'($urandom);
    writeReg(`UART_ADDR_LCR, v);
    readReg(`UART_ADDR_LCR, rdata);
    compareByte("LCR readback", rdata, v);
    writeReg(`UART_ADDR_LCR, 8'h03);
    v = byteT'($urandom);
    ierVal = v & 8'h0F;  // only the low nibble exists
    writeReg(`UART_ADDR_IER_DLM, v);
    readReg(`UART_ADDR_IER_DLM, rdata);
    compareByte("IER readback", rdata, ierVal);
    v = byteT'($urandom);
    writeReg(`UART_ADDR_MCR, v);
    readReg(`UART_ADDR_MCR, rdata);
    compareByte("MCR readback", rdata, v & 8'h1F);
    dllVal = byteT'($urandom);
    dlmVal = byteT'($urandom);
    writeReg(`UART_ADDR_LCR, 8'h83);
    writeReg(`UART_ADDR_RBR_DLL, dllVal);
    writeReg(`UART_ADDR_IER_DLM, dlmVal);
    readReg(`UART_ADDR_RBR_DLL, rdata);
    compareByte("DLL readback", rdata, dllVal);
    readReg(`UART_ADDR_IER_DLM, rdata);
    compareByte("DLM readback", rdata, dlmVal);
    writeReg(`UART_ADDR_LCR, 8'h03);
    readReg(`UART_ADDR_IER_DLM, rdata);
    compareByte("IER after divisor writes", rdata, ierVal);
    writeReg(`UART_ADDR_IER_DLM, 8'h00);
    writeReg(`UART_ADDR_MCR, 8'h00);
  endtask

  task automatic transmitFrames();
    byteT data;
    byteT lcrVal;
    byteT rdata;
    writeReg(`UART_ADDR_LCR, 8'h80);
    writeReg(`UART_ADDR_RBR_DLL, byteT'(TxDivisor));
    writeReg(`UART_ADDR_IER_DLM, 8'h00);
    for (int f = 0; f < NumFrames; f++) begin
      data   = byteT'($urandom);
      lcrVal = byteT'($urandom) & 8'h1F;  // word length, stop, parity enable, even
      writeReg(`UART_ADDR_LCR, lcrVal);
      readReg(`UART_ADDR_LSR, rdata);
      compareByte("LSR THRE before write", {7'b0, rdata[5]}, 8'h01);
      writeReg(`UART_ADDR_RBR_DLL, data);
      decodeFrame(data, lcrVal);
    end
  endtask

  task automatic threInterrupt();
    byteT rdata;
    writeReg(`UART_ADDR_LCR, 8'h03);
    writeReg(`UART_ADDR_IER_DLM, 8'h02);
    repeat (2) @(negedge PCLK);
    compareByte("INTR with THRE pending", {7'b0, INTR}, 8'h01);
    readReg(`UART_ADDR_IIR, rdata);
    compareByte("IIR pending", rdata, 8'h02);
    readReg(`UART_ADDR_IIR, rdata);  // previous read acknowledged it
    compareByte("IIR after acknowledge", rdata, 8'h01);
    repeat (2) @(negedge PCLK);
    compareByte("INTR after acknowledge", {7'b0, INTR}, 8'h00);
    writeReg(`UART_ADDR_RBR_DLL, byteT'($urandom));
    repeat (2) @(negedge PCLK);  // byte moves into the shifter
    readReg(`UART_ADDR_LSR, rdata);
    compareByte("LSR THRE after move", {7'b0, rdata[5]}, 8'h01);
    readReg(`UART_ADDR_IIR, rdata);
    compareByte("IIR re-armed", rdata, 8'h02);
    waitTxEmpty((MaxFrameBits + 2) * BitCycles / 2);
    writeReg(`UART_ADDR_IER_DLM, 8'h00);
  endtask

  task automatic modemStatus();
    byteT rdata;
    writeReg(`UART_ADDR_MCR, 8'h00);
    readReg(`UART_ADDR_MSR, rdata);  // drop deltas left by earlier MCR writes
    @(negedge PCLK);
    CTSb = 1'b0;
    DSRb = 1'b0;
    DCDb = 1'b0;
    RIb  = 1'b0;  // leading edge of RI, no delta
    repeat (6) @(negedge PCLK);
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR after falling inputs", rdata, {~DCDb, ~RIb, ~DSRb, ~CTSb, 4'b1011});
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR second read", rdata, {~DCDb, ~RIb, ~DSRb, ~CTSb, 4'b0000});
    @(negedge PCLK);
    RIb  = 1'b1;  // trailing edge of RI
    CTSb = 1'b1;
    repeat (6) @(negedge PCLK);
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR after RI and CTS rise", rdata, {~DCDb, ~RIb, ~DSRb, ~CTSb, 4'b0101});
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR second read", rdata, {~DCDb, ~RIb, ~DSRb, ~CTSb, 4'b0000});
    @(negedge PCLK);
    DSRb = 1'b1;
    DCDb = 1'b1;
    repeat (6) @(negedge PCLK);
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR after DSR and DCD rise", rdata, {~DCDb, ~RIb, ~DSRb, ~CTSb, 4'b1010});
  endtask

  task automatic loopback();
    byteT rdata;
    writeReg(`UART_ADDR_MCR, 8'h0F);  // all outputs on, no loopback
    compareByte("modem outputs driven", {4'h0, OUT2b, OUT1b, RTSb, DTRb}, 8'h00);
    writeReg(`UART_ADDR_MCR, 8'h1F);  // all outputs on, loopback
    repeat (6) @(negedge PCLK);
    compareByte("modem outputs in loopback", {4'h0, OUT2b, OUT1b, RTSb, DTRb}, 8'h0F);
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR levels, MCR 1F", {4'h0, rdata[7:4]}, 8'h0F);
    writeReg(`UART_ADDR_MCR, 8'h10);  // loopback, outputs off
    repeat (6) @(negedge PCLK);
    readReg(`UART_ADDR_MSR, rdata);
    compareByte("MSR levels, MCR 10", {4'h0, rdata[7:4]}, 8'h00);
    writeReg(`UART_ADDR_MCR, 8'h00);
  endtask

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  initial begin : watchdog
    while (cycleCount < CycleLimit) begin
      @(posedge PCLK);
      cycleCount++;
    end
    $display("timeout: run did not finish within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : mainSequence
    void'($urandom(32'h5c10));  // one seed for the whole run
    PRESETn = 1'b0;
    A       = '0;
    Din     = '0;
    MEMRb   = 1'b1;
    MEMWb   = 1'b1;
    DSRb    = 1'b1;  // modem inputs inactive
    DCDb    = 1'b1;
    CTSb    = 1'b1;
    RIb     = 1'b1;
    repeat (16) @(negedge PCLK);
    PRESETn = 1'b1;
    resetValues();
    reportTest(1, "reset values");
    registerAccess();
    reportTest(2, "register access");
    transmitFrames();
    reportTest(3, "transmission");
    threInterrupt();
    reportTest(4, "THRE interrupt");
    modemStatus();
    reportTest(5, "modem status");
    loopback();
    reportTest(6, "loopback");
    $display("tests: 6 run, %0d failed, %0d errors", failedTests, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uartTop.f */
+incdir+design
design/uartPkg.sv
design/uartIf.sv
design/baudGen.sv
design/uartTx.sv
design/modemLoopback.sv
design/modemLineMonitor.sv
design/uartRegs.sv
design/uartTop.sv
tests/uartTb.sv

/* Bender.yml */
package:
  name: uart_tx

sources:
  - include_dirs:
      - design
    files:
      - design/uartPkg.sv
      - design/uartIf.sv
      - design/baudGen.sv
      - design/uartTx.sv
      - design/modemLoopback.sv
      - design/modemLineMonitor.sv
      - design/uartRegs.sv
      - design/uartTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/uartTb.sv
